//--- address_map.sv
`timescale 1ns/1ps

module address_map (
  input  cart_pkg::snes_addr_t snes_addr,
  input  cart_pkg::mapper_t    mapper,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::snes_addr_t saveram_mask,
  input  logic                 snes_read,
  input  logic                 snes_write,
  input  logic                 snes_cs,
  output cart_pkg::snes_addr_t mapped_addr,
  output logic                 is_rom,
  output logic                 is_saveram,
  output logic                 is_writable,
  output logic                 snes_databus_oe
);
  import cart_pkg::*;

  logic       rom_hit;
  logic       sram_hit;
  snes_addr_t rom_map;
  snes_addr_t sram_map;

  always_comb begin
    if (!mapper) begin
      // LoROM maps 32K pages in the upper half of each bank
      rom_hit  = snes_addr[22] | snes_addr[15];
      sram_hit = (&snes_addr[22:20]) & (snes_addr[19:16] < 4'hE) & ~snes_addr[15];
      rom_map  = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
      sram_map = SAVERAM_BASE + ({8'h00, snes_addr[15:0]} & saveram_mask);
    end else begin
      // HiROM maps linear 64K banks
      rom_hit  = snes_addr[22] | snes_addr[15];
      sram_hit = (snes_addr[22:21] == 2'b01) & (snes_addr[15:13] == 3'b011);
      rom_map  = {2'b00, snes_addr[21:0]} & rom_mask;
      sram_map = SAVERAM_BASE + ({11'h000, snes_addr[12:0]} & saveram_mask);
    end
  end

  // Save RAM overrides overlapping ROM
  assign is_saveram  = sram_hit;
  assign is_rom      = rom_hit & ~sram_hit;
  assign is_writable = sram_hit;
  assign mapped_addr = sram_hit ? sram_map : rom_map;

  // Active low
  assign snes_databus_oe = ~((is_rom & ~snes_cs) |
                             (is_saveram & ~(snes_read & snes_write)));

endmodule

//--- cart_pkg.sv
package cart_pkg;

  //////////////////////////////
  // Bus and data widths
  //////////////////////////////

  // Console or MCU byte address
  typedef logic [23:0] snes_addr_t;
  // PSRAM word address
  typedef logic [22:0] rom_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  // 0 is LoROM, 1 is HiROM
  typedef logic        mapper_t;

  //////////////////////////////
  // Arbiter states
  //////////////////////////////

  typedef enum logic [4:0] {
    ST_IDLE,
    ST_SNES_RD_ADDR,
    ST_SNES_RD_WAIT,
    ST_SNES_RD_END,
    ST_SNES_WR_ADDR,
    ST_SNES_WR_WAIT1,
    ST_SNES_WR_DATA,
    ST_SNES_WR_WAIT2,
    ST_SNES_WR_END,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_WAIT,
    ST_MCU_RD_WAIT2,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_WAIT,
    ST_MCU_WR_WAIT2,
    ST_MCU_WR_END
  } arb_state_t;

  // Strobe sample history length
  localparam int SYNC_DEPTH = 6;

  // PSRAM wait counts in CLK2 cycles
  localparam logic [3:0] ROM_RD_WAIT     = 4'd4;
  localparam logic [3:0] ROM_RD_WAIT_MCU = 4'd6;
  localparam logic [3:0] ROM_WR_WAIT1    = 4'd2;
  localparam logic [3:0] ROM_WR_WAIT2    = 4'd3;
  localparam logic [3:0] ROM_WR_WAIT_MCU = 4'd6;
  localparam logic [3:0] MCU_RECOVER     = 4'd2;

  // Save RAM sits at the top of PSRAM
  localparam snes_addr_t SAVERAM_BASE = 24'hE00000;

  // Config register select
  localparam logic [1:0] CFG_MAPPER       = 2'd0;
  localparam logic [1:0] CFG_ROM_MASK     = 2'd1;
  localparam logic [1:0] CFG_SAVERAM_MASK = 2'd2;

endpackage

//--- cart_top.f
cart_pkg.sv
snes_bus_sync.sv
mapper_config.sv
address_map.sv
mem_arbiter.sv
cart_top.sv
tb_clock.sv
tb_psram_model.sv
tb_cart.sv

//--- cart_top.sv
`timescale 1ns/1ps

module cart_top (
  input  logic                 CLK2,
  input  logic                 rst,
  // Console bus
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic                 snes_read,
  input  logic                 snes_write,
  input  logic                 snes_cs,
  input  logic                 snes_cpu_clk,
  input  cart_pkg::byte_t      snes_data_in,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_databus_oe,
  output logic                 snes_databus_dir,
  // PSRAM
  output cart_pkg::rom_addr_t  rom_addr,
  input  cart_pkg::word_t      rom_rdata,
  output cart_pkg::word_t      rom_wdata,
  output logic                 rom_data_oe,
  output logic                 rom_we,
  output logic                 rom_bhe,
  output logic                 rom_ble,
  // MCU side
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_dout,
  output cart_pkg::byte_t      mcu_din,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output logic                 mcu_rdy,
  input  logic                 cfg_we,
  input  logic [1:0]           cfg_sel,
  input  cart_pkg::snes_addr_t cfg_data
);
  import cart_pkg::*;

  logic       rd_start;
  logic       wr_start;
  logic       cycle_start;
  logic       cycle_end;
  mapper_t    mapper;
  snes_addr_t rom_mask;
  snes_addr_t saveram_mask;
  snes_addr_t mapped_addr;
  logic       is_writable;

  snes_bus_sync bus_sync_inst (
    .CLK2         (CLK2),
    .rst          (rst),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_cpu_clk (snes_cpu_clk),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end)
  );

  mapper_config config_inst (
    .CLK2         (CLK2),
    .rst          (rst),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_data     (cfg_data),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  // Region flags other than writable only steer the data bus enable
  address_map addr_map_inst (
    .snes_addr       (snes_addr),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .saveram_mask    (saveram_mask),
    .snes_read       (snes_read),
    .snes_write      (snes_write),
    .snes_cs         (snes_cs),
    .mapped_addr     (mapped_addr),
    .is_rom          (),
    .is_saveram      (),
    .is_writable     (is_writable),
    .snes_databus_oe (snes_databus_oe)
  );

  mem_arbiter arbiter_inst (
    .CLK2             (CLK2),
    .rst              (rst),
    .rd_start         (rd_start),
    .wr_start         (wr_start),
    .cycle_start      (cycle_start),
    .cycle_end        (cycle_end),
    .mapped_addr      (mapped_addr),
    .mcu_addr         (mcu_addr),
    .is_writable      (is_writable),
    .snes_read        (snes_read),
    .snes_cpu_clk     (snes_cpu_clk),
    .snes_data_in     (snes_data_in),
    .mcu_dout         (mcu_dout),
    .rom_rdata        (rom_rdata),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .rom_addr         (rom_addr),
    .rom_wdata        (rom_wdata),
    .rom_data_oe      (rom_data_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .snes_data_out    (snes_data_out),
    .mcu_din          (mcu_din),
    .mcu_rdy          (mcu_rdy),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

//--- mapper_config.sv
`timescale 1ns/1ps

module mapper_config (
  input  logic                CLK2,
  input  logic                rst,
  input  logic                cfg_we,
  input  logic [1:0]          cfg_sel,
  input  cart_pkg::snes_addr_t cfg_data,
  output cart_pkg::mapper_t   mapper,
  output cart_pkg::snes_addr_t rom_mask,
  output cart_pkg::snes_addr_t saveram_mask
);
  import cart_pkg::*;

  //////////////////////////////
  // MCU config registers
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      mapper       <= 1'b0;
      rom_mask     <= '0;
      saveram_mask <= '0;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_MAPPER: begin
          // Only bit 0 selects the mapper
          mapper <= cfg_data[0];
        end
        CFG_ROM_MASK: begin
          rom_mask <= cfg_data;
        end
        CFG_SAVERAM_MASK: begin
          saveram_mask <= cfg_data;
        end
        default: begin
          // Spare index drops the write
        end
      endcase
    end
  end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                 CLK2,
  input  logic                 rst,
  input  logic                 rd_start,
  input  logic                 wr_start,
  input  logic                 cycle_start,
  input  logic                 cycle_end,
  input  cart_pkg::snes_addr_t mapped_addr,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  logic                 is_writable,
  input  logic                 snes_read,
  input  logic                 snes_cpu_clk,
  input  cart_pkg::byte_t      snes_data_in,
  input  cart_pkg::byte_t      mcu_dout,
  input  cart_pkg::word_t      rom_rdata,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output cart_pkg::rom_addr_t  rom_addr,
  output cart_pkg::word_t      rom_wdata,
  output logic                 rom_data_oe,
  output logic                 rom_we,
  output logic                 rom_bhe,
  output logic                 rom_ble,
  output cart_pkg::byte_t      snes_data_out,
  output cart_pkg::byte_t      mcu_din,
  output logic                 mcu_rdy,
  output logic                 snes_databus_dir
);
  import cart_pkg::*;

  arb_state_t state;
  logic [3:0] delay;
  logic       rd_pend;
  logic       wr_pend;
  logic       need_snes_addr;
  logic       assert_snes_addr;
  logic       snes_wr_cycle;
  logic       rom_we_q;
  logic       wr_state;
  logic       rd_state;
  snes_addr_t addr_q;
  snes_addr_t cur_addr;
  byte_t      wdata_q;
  byte_t      rd_byte;

  // Console wants its address from clock fall or read strobe until its access ends
  always_ff @(posedge CLK2) begin
    if (rst) begin
      need_snes_addr <= 1'b0;
    end else if (cycle_end || rd_start) begin
      need_snes_addr <= 1'b1;
    end else if (state == ST_SNES_RD_END || state == ST_SNES_WR_END) begin
      need_snes_addr <= 1'b0;
    end
  end

  //////////////////////////////
  // MCU request tracking
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq && mcu_rdy) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq && mcu_rdy) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == ST_MCU_RD_END || state == ST_MCU_WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  //////////////////////////////
  // Arbiter FSM
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state         <= ST_IDLE;
      delay         <= '0;
      rom_we_q      <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (cycle_start) begin
      // Console cycle preempts anything in flight
      state         <= ST_SNES_RD_ADDR;
      rom_we_q      <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (wr_start) begin
      state    <= ST_SNES_WR_ADDR;
      rom_we_q <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rd_pend) begin
            state <= ST_MCU_RD_ADDR;
          end else if (wr_pend) begin
            state <= ST_MCU_WR_ADDR;
          end
        end
        ST_SNES_RD_ADDR: begin
          state <= ST_SNES_RD_WAIT;
          delay <= ROM_RD_WAIT;
        end
        ST_SNES_RD_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_SNES_RD_END;
          end
        end
        ST_SNES_RD_END: begin
          state <= ST_IDLE;
        end
        ST_SNES_WR_ADDR: begin
          // Writes to ROM keep WE high
          rom_we_q      <= ~is_writable;
          snes_wr_cycle <= 1'b1;
          state         <= ST_SNES_WR_WAIT1;
          delay         <= ROM_WR_WAIT1;
        end
        ST_SNES_WR_WAIT1: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_SNES_WR_DATA;
          end
        end
        ST_SNES_WR_DATA: begin
          state <= ST_SNES_WR_WAIT2;
          delay <= ROM_WR_WAIT2;
        end
        ST_SNES_WR_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_SNES_WR_END;
          end
        end
        ST_SNES_WR_END: begin
          state         <= ST_IDLE;
          rom_we_q      <= 1'b1;
          snes_wr_cycle <= 1'b0;
        end
        ST_MCU_RD_ADDR: begin
          state <= ST_MCU_RD_WAIT;
          delay <= ROM_RD_WAIT_MCU;
        end
        ST_MCU_RD_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_MCU_RD_WAIT2;
            delay <= MCU_RECOVER;
          end
        end
        ST_MCU_RD_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_MCU_RD_END;
          end
        end
        ST_MCU_WR_ADDR: begin
          state    <= ST_MCU_WR_WAIT;
          delay    <= ROM_WR_WAIT_MCU;
          rom_we_q <= 1'b0;
        end
        ST_MCU_WR_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            rom_we_q <= 1'b1;
            state    <= ST_MCU_WR_WAIT2;
            delay    <= MCU_RECOVER;
          end
        end
        ST_MCU_WR_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ST_MCU_WR_END;
          end
        end
        default: begin
          // MCU_RD_END and MCU_WR_END
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and data captures
  always_ff @(posedge CLK2) begin
    case (state)
      ST_IDLE: begin
        addr_q <= mapped_addr;
      end
      ST_SNES_RD_WAIT, ST_SNES_RD_END: begin
        snes_data_out <= rd_byte;
      end
      ST_SNES_WR_DATA: begin
        wdata_q <= snes_data_in;
      end
      ST_MCU_RD_ADDR: begin
        addr_q <= mcu_addr;
      end
      ST_MCU_RD_WAIT: begin
        mcu_din <= rd_byte;
      end
      ST_MCU_WR_ADDR: begin
        addr_q  <= mcu_addr;
        wdata_q <= mcu_dout;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // PSRAM drive
  //////////////////////////////

  assign assert_snes_addr = snes_cpu_clk & need_snes_addr;
  assign cur_addr = assert_snes_addr ? mapped_addr : addr_q;
  assign rom_addr = cur_addr[23:1];

  // Odd addresses live in the low byte
  assign rd_byte = cur_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];

  assign rom_we = rom_we_q | (assert_snes_addr & ~snes_wr_cycle);
  assign rom_wdata = {wdata_q, wdata_q};

  assign wr_state = state inside {ST_SNES_WR_WAIT1, ST_SNES_WR_DATA, ST_SNES_WR_WAIT2,
                                  ST_SNES_WR_END, ST_MCU_WR_WAIT};
  assign rd_state = state inside {ST_SNES_RD_ADDR, ST_SNES_RD_WAIT, ST_SNES_RD_END,
                                  ST_MCU_RD_ADDR, ST_MCU_RD_WAIT, ST_MCU_RD_WAIT2,
                                  ST_MCU_RD_END};
  assign rom_data_oe = wr_state & ~rom_we;

  // Byte enables active high, both lanes on reads
  assign rom_bhe = rom_we | ~cur_addr[0];
  assign rom_ble = rom_we | cur_addr[0];

  assign snes_databus_dir = ~snes_read;

  // MCU only requests while ready
  assert property (@(posedge CLK2) disable iff (rst) (mcu_rrq || mcu_wrq) |-> mcu_rdy)
    else $error("MCU request while busy");

  assert property (@(posedge CLK2) disable iff (rst) rd_state |-> rom_we)
    else $error("PSRAM write strobe in a read state");

  // Data drive and write strobe move together
  assert property (@(posedge CLK2) disable iff (rst) rom_data_oe == !rom_we)
    else $error("PSRAM data drive out of step with write strobe");

endmodule

//--- snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic CLK2,
  input  logic rst,
  input  logic snes_read,
  input  logic snes_write,
  input  logic snes_cpu_clk,
  output logic rd_start,
  output logic wr_start,
  output logic cycle_start,
  output logic cycle_end
);
  import cart_pkg::*;

  logic [SYNC_DEPTH-1:0] read_hist;
  logic [SYNC_DEPTH-1:0] write_hist;
  logic [SYNC_DEPTH-1:0] clk_hist;

  // Newest sample enters at bit 0
  always_ff @(posedge CLK2) begin
    if (rst) begin
      read_hist  <= '1;
      write_hist <= '1;
      clk_hist   <= '0;
    end else begin
      read_hist  <= {read_hist[SYNC_DEPTH-2:0], snes_read};
      write_hist <= {write_hist[SYNC_DEPTH-2:0], snes_write};
      clk_hist   <= {clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // Strobes fall after a stable high run
  assign rd_start = (read_hist == {{(SYNC_DEPTH-1){1'b1}}, 1'b0});
  assign wr_start = (write_hist == {{(SYNC_DEPTH-1){1'b1}}, 1'b0});

  // CPU clock edges after a stable run
  assign cycle_start = (clk_hist == {{(SYNC_DEPTH-1){1'b0}}, 1'b1});
  assign cycle_end   = (clk_hist == {{(SYNC_DEPTH-1){1'b1}}, 1'b0});

endmodule

//--- tb_cart.sv
`timescale 1ns/1ps

module tb_cart;
  import cart_pkg::*;

  logic       CLK2;
  logic       rst;
  snes_addr_t snes_addr;
  logic       snes_read;
  logic       snes_write;
  logic       snes_cs;
  logic       snes_cpu_clk;
  byte_t      snes_data_in;
  byte_t      snes_data_out;
  logic       snes_databus_oe;
  logic       snes_databus_dir;
  rom_addr_t  rom_addr;
  word_t      rom_rdata;
  word_t      rom_wdata;
  logic       rom_data_oe;
  logic       rom_we;
  logic       rom_bhe;
  logic       rom_ble;
  snes_addr_t mcu_addr;
  byte_t      mcu_dout;
  byte_t      mcu_din;
  logic       mcu_rrq;
  logic       mcu_wrq;
  logic       mcu_rdy;
  logic       cfg_we;
  logic [1:0] cfg_sel;
  snes_addr_t cfg_data;

  logic [31:0] rng_state = 32'hda20;
  byte_t       mcu_bytes [4];
  byte_t       rom_bytes [2];

  tb_clock clock_inst (
    .CLK2 (CLK2),
    .rst  (rst)
  );

  tb_psram_model psram_inst (
    .CLK2      (CLK2),
    .rom_addr  (rom_addr),
    .rom_wdata (rom_wdata),
    .rom_we    (rom_we),
    .rom_bhe   (rom_bhe),
    .rom_ble   (rom_ble),
    .rom_rdata (rom_rdata)
  );

  cart_top cart_top_inst (
    .CLK2 (CLK2), .rst (rst),
    .snes_addr (snes_addr), .snes_read (snes_read), .snes_write (snes_write),
    .snes_cs (snes_cs), .snes_cpu_clk (snes_cpu_clk), .snes_data_in (snes_data_in),
    .snes_data_out (snes_data_out), .snes_databus_oe (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir),
    .rom_addr (rom_addr), .rom_rdata (rom_rdata), .rom_wdata (rom_wdata),
    .rom_data_oe (rom_data_oe), .rom_we (rom_we), .rom_bhe (rom_bhe), .rom_ble (rom_ble),
    .mcu_addr (mcu_addr), .mcu_dout (mcu_dout), .mcu_din (mcu_din),
    .mcu_rrq (mcu_rrq), .mcu_wrq (mcu_wrq), .mcu_rdy (mcu_rdy),
    .cfg_we (cfg_we), .cfg_sel (cfg_sel), .cfg_data (cfg_data)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic byte_t rand_byte();
    rng_state = xorshift(rng_state);
    return rng_state[7:0];
  endfunction

  // LoROM packs 32K pages behind the 7-bit bank number
  function automatic snes_addr_t lorom_rom(input snes_addr_t a, input snes_addr_t mask);
    return ((((a >> 16) & 24'h7F) << 15) | (a & 24'h7FFF)) & mask;
  endfunction

  function automatic snes_addr_t hirom_rom(input snes_addr_t a, input snes_addr_t mask);
    return (a & 24'h3FFFFF) & mask;
  endfunction

  function automatic snes_addr_t lorom_sram(input snes_addr_t a, input snes_addr_t mask);
    return SAVERAM_BASE + ((a & 24'h00FFFF) & mask);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERR %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic wait_mcu_ready();
    int n;
    n = 0;
    @(negedge CLK2);
    while (mcu_rdy !== 1'b1) begin
      if (n == 400) begin
        report_failure("MCU access did not finish, mcu_rdy stayed low");
      end
      n++;
      @(negedge CLK2);
    end
  endtask

  task automatic mcu_write(input snes_addr_t addr, input byte_t data);
    wait_mcu_ready();
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_dout <= data;
    mcu_wrq  <= 1'b1;
    @(posedge CLK2);
    mcu_wrq <= 1'b0;
    wait_mcu_ready();
  endtask

  task automatic mcu_read(input snes_addr_t addr, output byte_t data);
    wait_mcu_ready();
    @(posedge CLK2);
    mcu_addr <= addr;
    mcu_rrq  <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    wait_mcu_ready();
    data = mcu_din;
  endtask

  task automatic write_config(input logic [1:0] sel, input snes_addr_t data);
    @(posedge CLK2);
    cfg_we   <= 1'b1;
    cfg_sel  <= sel;
    cfg_data <= data;
    @(posedge CLK2);
    cfg_we <= 1'b0;
  endtask

  // Clock low 6 cycles, then high 14 with read and chip select low
  task automatic snes_read_cycle(input snes_addr_t addr, output byte_t data,
                                 output logic oe, output logic dir);
    @(posedge CLK2);
    snes_addr    <= addr;
    snes_cpu_clk <= 1'b0;
    snes_read    <= 1'b1;
    snes_cs      <= 1'b1;
    repeat (6) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    snes_read    <= 1'b0;
    snes_cs      <= 1'b0;
    repeat (13) @(posedge CLK2);
    @(negedge CLK2);
    data = snes_data_out;
    oe   = snes_databus_oe;
    dir  = snes_databus_dir;
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    snes_read    <= 1'b1;
    snes_cs      <= 1'b1;
  endtask

  // Write strobe falls a few cycles into the high phase
  task automatic snes_write_cycle(input snes_addr_t addr, input byte_t data);
    @(posedge CLK2);
    snes_addr    <= addr;
    snes_cpu_clk <= 1'b0;
    snes_write   <= 1'b1;
    snes_cs      <= 1'b1;
    repeat (6) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    snes_cs      <= 1'b0;
    repeat (3) @(posedge CLK2);
    snes_write   <= 1'b0;
    snes_data_in <= data;
    repeat (16) @(posedge CLK2);
    snes_write <= 1'b1;
    repeat (2) @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    snes_cs      <= 1'b1;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_state();
    @(negedge CLK2);
    check_bit("reset_state mcu_rdy", 1'b1, mcu_rdy);
    check_bit("reset_state rom_we", 1'b1, rom_we);
    check_bit("reset_state rom_data_oe", 1'b0, rom_data_oe);
  endtask

  task automatic mcu_write_read();
    snes_addr_t addrs [4];
    word_t      w;
    byte_t      got;
    addrs = '{24'h000010, 24'h000011, 24'h123457, 24'h3ABCDE};
    for (int i = 0; i < 4; i++) begin
      mcu_bytes[i] = rand_byte();
      mcu_write(addrs[i], mcu_bytes[i]);
      w = psram_inst.peek(addrs[i][23:1]);
      check_byte("mcu_write_read lane", mcu_bytes[i], addrs[i][0] ? w[7:0] : w[15:8]);
    end
    // Both lanes of one word, even address in the high byte
    check_word("mcu_write_read word", {mcu_bytes[0], mcu_bytes[1]}, psram_inst.peek(23'h8));
    for (int i = 0; i < 4; i++) begin
      mcu_read(addrs[i], got);
      check_byte("mcu_write_read data", mcu_bytes[i], got);
    end
  endtask

  task automatic lorom_console_read();
    snes_addr_t addrs [2];
    byte_t      got;
    logic       oe;
    logic       dir;
    addrs = '{24'h819ABC, 24'h05C321};
    write_config(CFG_ROM_MASK, 24'hFFFFFF);
    for (int i = 0; i < 2; i++) begin
      rom_bytes[i] = rand_byte();
      mcu_write(lorom_rom(addrs[i], 24'hFFFFFF), rom_bytes[i]);
      snes_read_cycle(addrs[i], got, oe, dir);
      check_byte("lorom_console_read data", rom_bytes[i], got);
      check_bit("lorom_console_read oe", 1'b0, oe);
      check_bit("lorom_console_read dir", 1'b1, dir);
    end
    @(negedge CLK2);
    check_bit("lorom_console_read oe idle", 1'b1, snes_databus_oe);
  endtask

  task automatic hirom_mask_alias();
    snes_addr_t a;
    byte_t      d;
    byte_t      got;
    logic       oe;
    logic       dir;
    a = 24'hE52345;
    d = rand_byte();
    write_config(CFG_MAPPER, 24'h000001);
    write_config(CFG_ROM_MASK, 24'h0FFFFF);
    mcu_write(hirom_rom(a, 24'h0FFFFF), d);
    mcu_write(a & 24'h3FFFFF, ~d);
    snes_read_cycle(a, got, oe, dir);
    check_byte("hirom_mask_alias data", d, got);
  endtask

  task automatic console_write_permission();
    snes_addr_t sram_a;
    snes_addr_t rom_a;
    byte_t      d;
    byte_t      got;
    sram_a = 24'h701234;
    rom_a  = 24'h819ABC;
    write_config(CFG_MAPPER, 24'h000000);
    write_config(CFG_ROM_MASK, 24'hFFFFFF);
    write_config(CFG_SAVERAM_MASK, 24'h001FFF);
    d = rand_byte();
    mcu_write(lorom_sram(sram_a, 24'h001FFF), ~d);
    snes_write_cycle(sram_a, d);
    mcu_read(lorom_sram(sram_a, 24'h001FFF), got);
    check_byte("console_write_permission saveram", d, got);
    // ROM stays intact under a console write
    d = rand_byte();
    mcu_write(lorom_rom(rom_a, 24'hFFFFFF), d);
    snes_write_cycle(rom_a, ~d);
    mcu_read(lorom_rom(rom_a, 24'hFFFFFF), got);
    check_byte("console_write_permission rom", d, got);
  endtask

  task automatic mcu_read_under_console();
    byte_t got;
    byte_t console_got;
    logic  oe;
    logic  dir;
    fork
      begin
        repeat (5) begin
          snes_read_cycle(24'h05C321, console_got, oe, dir);
          check_byte("mcu_read_under_console console", rom_bytes[1], console_got);
        end
      end
      begin
        repeat (3) @(posedge CLK2);
        mcu_read(24'h123457, got);
        check_byte("mcu_read_under_console mcu", mcu_bytes[2], got);
      end
    join
  endtask

  initial begin
    int n;
    snes_addr    <= '0;
    snes_read    <= 1'b1;
    snes_write   <= 1'b1;
    snes_cs      <= 1'b1;
    snes_cpu_clk <= 1'b0;
    snes_data_in <= '0;
    mcu_addr     <= '0;
    mcu_dout     <= '0;
    mcu_rrq      <= 1'b0;
    mcu_wrq      <= 1'b0;
    cfg_we       <= 1'b0;
    cfg_sel      <= '0;
    cfg_data     <= '0;
    n = 0;
    while (rst !== 1'b0) begin
      if (n == 20) begin
        report_failure("Reset was never released");
      end
      n++;
      @(negedge CLK2);
    end
    reset_state();
    mcu_write_read();
    lorom_console_read();
    hirom_mask_alias();
    console_write_permission();
    mcu_read_under_console();
    $display("sim passed");
    $finish;
  end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic CLK2,
  output logic rst
);

  // 100 ns period
  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  // Reset held over the first two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge CLK2);
    rst <= 1'b0;
  end

endmodule

//--- tb_psram_model.sv
`timescale 1ns/1ps

module tb_psram_model (
  input  logic                CLK2,
  input  cart_pkg::rom_addr_t rom_addr,
  input  cart_pkg::word_t     rom_wdata,
  input  logic                rom_we,
  input  logic                rom_bhe,
  input  logic                rom_ble,
  output cart_pkg::word_t     rom_rdata
);
  import cart_pkg::*;

  // 64K words folded from the top and bottom of the word address
  word_t       mem [0:65535];
  logic [15:0] idx;

  function automatic logic [15:0] fold(input rom_addr_t a);
    return {a[22:20], a[12:0]};
  endfunction

  function automatic word_t peek(input rom_addr_t a);
    return mem[fold(a)];
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] <= {i[7:0] ^ 8'h5A, i[15:8] ^ 8'hC3};
    end
  end

  assign idx = fold(rom_addr);
  assign rom_rdata = mem[idx];

  // Byte enables active high
  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (rom_bhe) begin
        mem[idx][15:8] <= rom_wdata[15:8];
      end
      if (rom_ble) begin
        mem[idx][7:0] <= rom_wdata[7:0];
      end
    end
  end

endmodule
